// ==== exec_pkg.sv ====
package exec_pkg;

    // ==========================================================
    // Widths
    // ==========================================================

    // Data and PC width
    localparam int xlen = 32;

    // Physical register tag width
    localparam int tag_w = 6;

    // ==========================================================
    // Encodings
    // ==========================================================

    // ALU operation select
    typedef enum logic [3:0] {
        add    = 4'd0,
        sub    = 4'd1,
        sll    = 4'd2,
        slt    = 4'd3,
        sltu   = 4'd4,
        xor_op = 4'd5,
        srl    = 4'd6,
        sra    = 4'd7,
        or_op  = 4'd8,
        and_op = 4'd9,
        // Operand b straight through, used for LUI
        pass_b = 4'd10
    } alu_op_e;

    // Branch class, 1 to 5 are the conditional branches
    typedef enum logic [2:0] {
        br_none = 3'd0,
        br_beq  = 3'd1,
        br_bne  = 3'd2,
        br_blt  = 3'd3,
        br_bge  = 3'd4,
        br_bltu = 3'd5,
        br_jal  = 3'd6,
        br_jalr = 3'd7
    } branch_sel_e;

    // ==========================================================
    // Packets
    // ==========================================================

    // Issue packet from a reservation station
    typedef struct packed {
        logic [tag_w-1:0] tag;
        alu_op_e          alu_op;
        branch_sel_e      branch_sel;
        logic [xlen-1:0]  data_a;
        logic [xlen-1:0]  data_b;
        logic [xlen-1:0]  pc;
        // PC plus offset, only meaningful for conditional branches
        logic [xlen-1:0]  br_target;
        logic             pred_taken;
        logic [xlen-1:0]  pred_target;
    } issue_pkt_t;

    // Common data bus broadcast
    typedef struct packed {
        logic [tag_w-1:0] tag;
        logic [xlen-1:0]  data;
    } cdb_t;

    // Branch predictor training update
    typedef struct packed {
        logic [xlen-1:0] pc;
        logic            taken;
        logic [xlen-1:0] target;
        logic            is_jalr;
    } bp_update_t;

    // Front-end redirect
    typedef struct packed {
        logic [xlen-1:0]  pc;
        logic [tag_w-1:0] tag;
    } redirect_t;

endpackage

// ==== alu_shifter.sv ====
`timescale 1ns/1ns

module alu_shifter (
    input  logic [exec_pkg::xlen-1:0] data_a,
    input  logic [exec_pkg::xlen-1:0] data_b,
    input  exec_pkg::alu_op_e         op,
    output logic [exec_pkg::xlen-1:0] result,
    output logic                      zero,
    output logic                      lt,
    output logic                      ltu
);

    localparam int w = exec_pkg::xlen;

    // Subtract with borrow bit on top
    logic [w:0]   diff;
    logic         carry;
    logic         negative;
    logic         overflow;
    logic [4:0]   shamt;

    // ==========================================================
    // Compare flags from one subtract
    // ==========================================================

    assign diff     = {1'b0, data_a} - {1'b0, data_b};

    // Borrow out means a below b unsigned
    assign carry    = diff[w];
    assign negative = diff[w-1];

    // Signs of a and b differ and the difference flipped from a
    assign overflow = (data_a[w-1] ^ data_b[w-1]) & (data_a[w-1] ^ diff[w-1]);

    assign lt       = negative ^ overflow;
    assign ltu      = carry;

    // RV32I takes only the low five bits as shift amount
    assign shamt    = data_b[4:0];

    // ==========================================================
    // Operation select
    // ==========================================================

    always_comb begin
        case (op)
            exec_pkg::add:    result = data_a + data_b;
            exec_pkg::sub:    result = diff[w-1:0];
            exec_pkg::sll:    result = data_a << shamt;
            // Set-less-than results are zero extended flags
            exec_pkg::slt:    result = {{(w-1){1'b0}}, lt};
            exec_pkg::sltu:   result = {{(w-1){1'b0}}, ltu};
            exec_pkg::xor_op: result = data_a ^ data_b;
            exec_pkg::srl:    result = data_a >> shamt;
            // Arithmetic shift keeps the sign
            exec_pkg::sra:    result = $unsigned($signed(data_a) >>> shamt);
            exec_pkg::or_op:  result = data_a | data_b;
            exec_pkg::and_op: result = data_a & data_b;
            exec_pkg::pass_b: result = data_b;
            default:          result = '0;
        endcase
    end

    // Zero flag of whatever was selected
    assign zero = (result == '0);

endmodule

// ==== fu_lane.sv ====
`timescale 1ns/1ns

module fu_lane (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue_valid,
    input  exec_pkg::issue_pkt_t      issue_pkt,
    output logic                      cdb_valid,
    output exec_pkg::cdb_t            cdb,
    output logic                      bp_valid,
    output exec_pkg::bp_update_t      bp_update,
    output logic                      mispredict,
    output logic [exec_pkg::xlen-1:0] redir_pc
);

    // Decoded branch class
    logic is_cond;
    logic is_jal;
    logic is_jalr;

    // ALU hookup
    exec_pkg::alu_op_e         lane_op;
    logic [exec_pkg::xlen-1:0] alu_result;
    logic                      alu_zero;
    logic                      alu_lt;
    logic                      alu_ltu;

    // Resolution results before the output register
    logic                      taken;
    logic [exec_pkg::xlen-1:0] link_pc;
    logic [exec_pkg::xlen-1:0] jalr_target;
    logic                      mispredict_d;
    logic [exec_pkg::xlen-1:0] redir_pc_d;
    exec_pkg::cdb_t            cdb_d;
    exec_pkg::bp_update_t      bp_update_d;

    // ==========================================================
    // Decode and ALU
    // ==========================================================

    assign is_cond = (issue_pkt.branch_sel >= exec_pkg::br_beq) &&
                     (issue_pkt.branch_sel <= exec_pkg::br_bltu);
    assign is_jal  = (issue_pkt.branch_sel == exec_pkg::br_jal);
    assign is_jalr = (issue_pkt.branch_sel == exec_pkg::br_jalr);

    // Compare by subtract for branches, jalr adds base and offset
    assign lane_op = is_cond ? exec_pkg::sub :
                     is_jalr ? exec_pkg::add : issue_pkt.alu_op;

    alu_shifter u_alu (
        .data_a (issue_pkt.data_a),
        .data_b (issue_pkt.data_b),
        .op     (lane_op),
        .result (alu_result),
        .zero   (alu_zero),
        .lt     (alu_lt),
        .ltu    (alu_ltu)
    );

    // ==========================================================
    // Branch resolution
    // ==========================================================

    // Taken from the subtract flags
    always_comb begin
        case (issue_pkt.branch_sel)
            exec_pkg::br_beq:  taken = alu_zero;
            exec_pkg::br_bne:  taken = !alu_zero;
            exec_pkg::br_blt:  taken = alu_lt;
            exec_pkg::br_bge:  taken = !alu_lt;
            exec_pkg::br_bltu: taken = alu_ltu;
            default:           taken = 1'b0;
        endcase
    end

    // Return address for jal and jalr
    assign link_pc     = issue_pkt.pc + exec_pkg::xlen'(4);

    // Word aligned jump target
    assign jalr_target = {alu_result[exec_pkg::xlen-1:2], 2'b00};

    // Conditional compares direction, jalr compares the target
    assign mispredict_d = issue_valid &&
                          ((is_cond && (taken != issue_pkt.pred_taken)) ||
                           (is_jalr && (jalr_target != issue_pkt.pred_target)));

    // Corrected fetch PC
    assign redir_pc_d = is_jalr ? jalr_target :
                        taken   ? issue_pkt.br_target : link_pc;

    always_comb begin
        cdb_d.tag           = issue_pkt.tag;
        cdb_d.data          = (is_jal || is_jalr) ? link_pc : alu_result;
        bp_update_d.pc      = issue_pkt.pc;
        bp_update_d.taken   = is_jalr ? 1'b1 : taken;
        bp_update_d.target  = is_jalr ? jalr_target : issue_pkt.br_target;
        bp_update_d.is_jalr = is_jalr;
    end

    // ==========================================================
    // Output register
    // ==========================================================

    always_ff @(posedge clk) begin
        if (rst) begin
            cdb_valid  <= 1'b0;
            bp_valid   <= 1'b0;
            mispredict <= 1'b0;
        end else begin
            // Conditional branches never write a register
            cdb_valid  <= issue_valid && !is_cond;
            bp_valid   <= issue_valid && (is_cond || is_jalr);
            mispredict <= mispredict_d;
        end
    end

    // Payload, qualified by the valids above
    always_ff @(posedge clk) begin
        cdb       <= cdb_d;
        bp_update <= bp_update_d;
        redir_pc  <= redir_pc_d;
    end

endmodule

// ==== redirect_select.sv ====
`timescale 1ns/1ns

module redirect_select #(
    parameter int num_lanes = 3
) (
    input  logic [num_lanes-1:0]       mispredict,
    input  logic [exec_pkg::xlen-1:0]  redir_pc [num_lanes],
    input  logic [exec_pkg::tag_w-1:0] lane_tag [num_lanes],
    output logic                       redirect_valid,
    output exec_pkg::redirect_t        redirect
);

    // Any lane wrong means the front end must restart
    assign redirect_valid = |mispredict;

    // ==========================================================
    // Priority pick, lowest lane is oldest
    // ==========================================================

    always_comb begin
        // Lane 0 when nothing mispredicts
        redirect.pc  = redir_pc[0];
        redirect.tag = lane_tag[0];

        // Walk downward so the lowest index is written last
        for (int i = num_lanes - 1; i >= 0; i--) begin
            if (mispredict[i]) begin
                redirect.pc  = redir_pc[i];
                redirect.tag = lane_tag[i];
            end
        end
    end

endmodule

// ==== execute_stage.sv ====
`timescale 1ns/1ns

module execute_stage #(
    parameter int num_lanes = 3
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [num_lanes-1:0] issue_valid,
    input  exec_pkg::issue_pkt_t issue_pkt [num_lanes],
    output logic [num_lanes-1:0] cdb_valid,
    output exec_pkg::cdb_t       cdb [num_lanes],
    output logic [num_lanes-1:0] bp_valid,
    output exec_pkg::bp_update_t bp_update [num_lanes],
    output logic                 redirect_valid,
    output exec_pkg::redirect_t  redirect
);

    // Registered lane results feeding the selector
    logic [num_lanes-1:0]       mispredict;
    logic [exec_pkg::xlen-1:0]  redir_pc [num_lanes];
    logic [exec_pkg::tag_w-1:0] lane_tag [num_lanes];

    // ==========================================================
    // Execute lanes
    // ==========================================================

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        fu_lane u_lane (
            .clk         (clk),
            .rst         (rst),
            .issue_valid (issue_valid[i]),
            .issue_pkt   (issue_pkt[i]),
            .cdb_valid   (cdb_valid[i]),
            .cdb         (cdb[i]),
            .bp_valid    (bp_valid[i]),
            .bp_update   (bp_update[i]),
            .mispredict  (mispredict[i]),
            .redir_pc    (redir_pc[i])
        );

        // Tag register holds the branch tag too
        assign lane_tag[i] = cdb[i].tag;
    end

    // Single redirect toward fetch
    redirect_select #(
        .num_lanes (num_lanes)
    ) u_redirect_select (
        .mispredict     (mispredict),
        .redir_pc       (redir_pc),
        .lane_tag       (lane_tag),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

endmodule

// ==== execute_stage_props.sv ====
`timescale 1ns/1ns

module execute_stage_props #(
    parameter int num_lanes = 3
) (
    input logic                 clk,
    input logic                 rst,
    input logic [num_lanes-1:0] issue_valid,
    input exec_pkg::issue_pkt_t issue_pkt [num_lanes],
    input logic [num_lanes-1:0] cdb_valid,
    input logic [num_lanes-1:0] bp_valid,
    input logic                 redirect_valid
);

    // Issued packets that must write the CDB
    logic [num_lanes-1:0] writes_cdb;

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        assign writes_cdb[i] = issue_valid[i] &&
                               ((issue_pkt[i].branch_sel < exec_pkg::br_beq) ||
                                (issue_pkt[i].branch_sel > exec_pkg::br_bltu));

        a_cdb_follows: assert property (@(posedge clk) disable iff (rst)
            writes_cdb[i] |=> cdb_valid[i])
            else $error("lane %0d cdb_valid missing after issue", i);
    end

    // Only a lane that trains the predictor can mispredict
    a_redirect_has_bp: assert property (@(posedge clk) disable iff (rst)
        redirect_valid |-> (|bp_valid))
        else $error("redirect_valid without any bp_valid");

    a_reset_idle: assert property (@(posedge clk)
        rst |=> ((cdb_valid == '0) && (bp_valid == '0) && !redirect_valid))
        else $error("valid output high during reset");

endmodule

bind execute_stage execute_stage_props #(.num_lanes(num_lanes)) u_props (
    .clk            (clk),
    .rst            (rst),
    .issue_valid    (issue_valid),
    .issue_pkt      (issue_pkt),
    .cdb_valid      (cdb_valid),
    .bp_valid       (bp_valid),
    .redirect_valid (redirect_valid)
);

// ==== tb_execute_stage.sv ====
`timescale 1ns/1ns

module tb_execute_stage;

    localparam int lanes = 3;
    localparam logic [31:0] seed = 32'h3ea98522;

    // Expected lane outputs for one issued packet
    typedef struct packed {
        logic                 cdb_valid;
        exec_pkg::cdb_t       cdb;
        logic                 bp_valid;
        exec_pkg::bp_update_t bp_update;
        logic                 mispredict;
        logic [31:0]          redir_pc;
    } expect_t;

    logic                 clk;
    logic                 rst;
    logic [lanes-1:0]     issue_valid;
    exec_pkg::issue_pkt_t issue_pkt [lanes];
    logic [lanes-1:0]     cdb_valid;
    exec_pkg::cdb_t       cdb [lanes];
    logic [lanes-1:0]     bp_valid;
    exec_pkg::bp_update_t bp_update [lanes];
    logic                 redirect_valid;
    exec_pkg::redirect_t  redirect;

    // Packets for the next drive, expectations for the next edge
    exec_pkg::issue_pkt_t next_pkt [lanes];
    expect_t              exp_q [lanes];
    logic [31:0]          lcg_state = seed;
    int                   errors = 0;
    int                   checks = 0;
    int                   tests = 0;
    int                   test_base = 0;

    execute_stage #(.num_lanes(lanes)) UUT (
        .clk            (clk),
        .rst            (rst),
        .issue_valid    (issue_valid),
        .issue_pkt      (issue_pkt),
        .cdb_valid      (cdb_valid),
        .cdb            (cdb),
        .bp_valid       (bp_valid),
        .bp_update      (bp_update),
        .redirect_valid (redirect_valid),
        .redirect       (redirect)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==========================================================
    // Random source and reference model
    // ==========================================================

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [31:0] alu_ref(input exec_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
        case (op)
            exec_pkg::add:    return a + b;
            exec_pkg::sub:    return a - b;
            exec_pkg::sll:    return a << b[4:0];
            exec_pkg::slt:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            exec_pkg::sltu:   return (a < b) ? 32'd1 : 32'd0;
            exec_pkg::xor_op: return a ^ b;
            exec_pkg::srl:    return a >> b[4:0];
            // Sign fill in the vacated top bits
            exec_pkg::sra:    return (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
            exec_pkg::or_op:  return a | b;
            exec_pkg::and_op: return a & b;
            exec_pkg::pass_b: return b;
            default:          return 32'd0;
        endcase
    endfunction

    function automatic expect_t ref_model(input logic valid, input exec_pkg::issue_pkt_t p);
        expect_t     e;
        logic        cond;
        logic        jump;
        logic        jalr;
        logic        taken;
        logic [31:0] tgt;
        logic [31:0] link;
        jalr = (p.branch_sel == exec_pkg::br_jalr);
        jump = jalr || (p.branch_sel == exec_pkg::br_jal);
        cond = (p.branch_sel != exec_pkg::br_none) && !jump;
        link = p.pc + 32'd4;
        // Jump target drops the two low bits
        tgt  = (p.data_a + p.data_b) & 32'hffff_fffc;
        case (p.branch_sel)
            exec_pkg::br_beq:  taken = (p.data_a == p.data_b);
            exec_pkg::br_bne:  taken = (p.data_a != p.data_b);
            exec_pkg::br_blt:  taken = ($signed(p.data_a) < $signed(p.data_b));
            exec_pkg::br_bge:  taken = ($signed(p.data_a) >= $signed(p.data_b));
            exec_pkg::br_bltu: taken = (p.data_a < p.data_b);
            default:           taken = 1'b0;
        endcase
        e.cdb_valid         = valid && !cond;
        e.cdb.tag           = p.tag;
        e.cdb.data          = jump ? link : alu_ref(p.alu_op, p.data_a, p.data_b);
        e.bp_valid          = valid && (cond || jalr);
        e.bp_update.pc      = p.pc;
        e.bp_update.taken   = jalr || taken;
        e.bp_update.target  = jalr ? tgt : p.br_target;
        e.bp_update.is_jalr = jalr;
        e.mispredict = valid && ((cond && (taken != p.pred_taken)) ||
                                 (jalr && (tgt != p.pred_target)));
        e.redir_pc   = jalr ? tgt : (taken ? p.br_target : link);
        return e;
    endfunction

    // Kind 0 ALU, 1 conditional branch, 2 jal or jalr
    function automatic exec_pkg::issue_pkt_t make_pkt(input int kind);
        exec_pkg::issue_pkt_t p;
        logic [31:0]          r;
        r             = lcg_next();
        p.tag         = r[5:0];
        p.alu_op      = exec_pkg::alu_op_e'(4'(r[15:8] % 8'd11));
        p.branch_sel  = exec_pkg::br_none;
        p.data_a      = lcg_next();
        // Equal operands now and then so beq and bge edges get hit
        p.data_b      = r[16] ? p.data_a : lcg_next();
        p.pc          = lcg_next() & 32'hffff_fffc;
        p.br_target   = lcg_next() & 32'hffff_fffc;
        p.pred_taken  = r[17];
        p.pred_target = r[19] ? ((p.data_a + p.data_b) & 32'hffff_fffc) : p.br_target;
        if (kind == 1) begin
            p.branch_sel = exec_pkg::branch_sel_e'(3'd1 + 3'(r[31:24] % 8'd5));
        end else if (kind == 2) begin
            p.branch_sel = r[18] ? exec_pkg::br_jalr : exec_pkg::br_jal;
        end
        return p;
    endfunction

    // ==========================================================
    // Checker
    // ==========================================================

    task automatic value_fail(input string name, input logic [95:0] expv,
                              input logic [95:0] got);
        errors++;
        $display("[FAIL] %s expected %h got %h", name, expv, got);
    endtask

    task automatic valid_fail(input string name, input logic expv);
        errors++;
        if (expv) begin
            $display("%s stayed low although a packet was issued a cycle before", name);
        end else begin
            $display("%s went high without a matching issue", name);
        end
    endtask

    task automatic compare_outputs();
        logic                exp_rv;
        exec_pkg::redirect_t exp_redir;
        exp_rv    = 1'b0;
        exp_redir = '0;
        // Oldest mispredicting lane wins, so scan from the top down
        for (int i = lanes - 1; i >= 0; i--) begin
            if (exp_q[i].mispredict) begin
                exp_rv        = 1'b1;
                exp_redir.pc  = exp_q[i].redir_pc;
                exp_redir.tag = exp_q[i].cdb.tag;
            end
        end
        for (int i = 0; i < lanes; i++) begin
            checks++;
            if (cdb_valid[i] !== exp_q[i].cdb_valid) begin
                valid_fail($sformatf("cdb_valid[%0d]", i), exp_q[i].cdb_valid);
            end else if (exp_q[i].cdb_valid && (cdb[i] !== exp_q[i].cdb)) begin
                value_fail($sformatf("cdb[%0d]", i), 96'(exp_q[i].cdb), 96'(cdb[i]));
            end
            if (bp_valid[i] !== exp_q[i].bp_valid) begin
                valid_fail($sformatf("bp_valid[%0d]", i), exp_q[i].bp_valid);
            end else if (exp_q[i].bp_valid && (bp_update[i] !== exp_q[i].bp_update)) begin
                value_fail($sformatf("bp_update[%0d]", i), 96'(exp_q[i].bp_update),
                           96'(bp_update[i]));
            end
        end
        checks++;
        if (redirect_valid !== exp_rv) begin
            valid_fail("redirect_valid", exp_rv);
        end else if (exp_rv && (redirect !== exp_redir)) begin
            value_fail("redirect", 96'(exp_redir), 96'(redirect));
        end
    endtask

    // Compare last cycle's expectations, then capture this cycle's issue
    initial begin : check_proc
        forever begin
            @(posedge clk);
            for (int i = 0; i < lanes; i++) begin
                if (rst) begin
                    exp_q[i] = '0;
                end
            end
            if (!rst) begin
                compare_outputs();
                for (int i = 0; i < lanes; i++) begin
                    exp_q[i] = ref_model(issue_valid[i], issue_pkt[i]);
                end
            end
        end
    end

    // ==========================================================
    // Stimulus
    // ==========================================================

    task automatic drive_cycle(input logic [lanes-1:0] v);
        @(negedge clk);
        issue_valid = v;
        for (int i = 0; i < lanes; i++) begin
            issue_pkt[i] = next_pkt[i];
        end
    endtask

    task automatic run_packets(input int kind, input int cycles);
        repeat (cycles) begin
            for (int i = 0; i < lanes; i++) begin
                next_pkt[i] = make_pkt(kind);
            end
            drive_cycle('1);
        end
    endtask

    // Stop issuing and wait for the lanes to drain
    task automatic finish_test(input string name);
        int waited;
        waited = 0;
        @(negedge clk);
        issue_valid = '0;
        while (((|cdb_valid) || (|bp_valid) || redirect_valid) && (waited < 8)) begin
            @(negedge clk);
            waited++;
        end
        if (waited >= 8) begin
            errors++;
            $display("timeout: lane outputs of test %s never returned to idle", name);
        end
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    initial begin : stimulus
        expect_t     probe;
        logic [31:0] r;
        logic [2:0]  mask;
        rst         = 1'b1;
        issue_valid = '0;
        for (int i = 0; i < lanes; i++) begin
            issue_pkt[i] = '0;
            next_pkt[i]  = '0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;

        repeat (10) @(negedge clk);
        finish_test("idle after reset");
        run_packets(0, 60);
        finish_test("alu and shift");
        run_packets(1, 60);
        finish_test("conditional branch");
        run_packets(2, 60);
        finish_test("jal and jalr");

        // Flip the prediction on at least two lanes per cycle
        repeat (40) begin
            r    = lcg_next();
            mask = (r[1:0] == 2'd0) ? 3'b011 : (r[1:0] == 2'd1) ? 3'b101 :
                   (r[1:0] == 2'd2) ? 3'b110 : 3'b111;
            for (int i = 0; i < lanes; i++) begin
                next_pkt[i] = make_pkt(1);
                probe = ref_model(1'b1, next_pkt[i]);
                next_pkt[i].pred_taken = probe.bp_update.taken ^ mask[i];
            end
            drive_cycle('1);
        end
        finish_test("multi-lane mispredict");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== project.f ====
exec_pkg.sv
alu_shifter.sv
fu_lane.sv
redirect_select.sv
execute_stage.sv
execute_stage_props.sv
tb_execute_stage.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f project.f \
    --top-module tb_execute_stage -o sim_execute_stage &&
./obj_dir/sim_execute_stage | tee /dev/stderr | grep -q "Simulation passed" &&
echo "run_sim: PASS" ||
{ echo "run_sim: FAIL"; exit 1; }
